// ==== design/inst_buffer_pkg.sv ====
package inst_buffer_pkg;

  // ----------------------------------------------------------------------
  // sizes and limits
  // ----------------------------------------------------------------------
  localparam int XLEN_PC            = 32;
  localparam int LINE_WORDS         = 4;
  localparam int LINE_W             = LINE_WORDS * 32;
  localparam int WORD_IDX_W         = 2;
  localparam int INST_BUF_SIZE      = 4;
  localparam int PTR_W              = 2;
  localparam int DISP_WIDTH         = 3;
  localparam int DISP_CNT_W         = 2;

  localparam int ARITH_DISP_LIMIT   = 2;
  localparam int MEM_DISP_LIMIT     = 1;  // load and store together
  localparam int BR_DISP_LIMIT      = 1;
  localparam int ILLEGAL_DISP_LIMIT = 1;

  // ----------------------------------------------------------------------
  // RV32 major opcodes
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef enum logic [2:0] {
    CAT_ARITH,
    CAT_LD,
    CAT_ST,
    CAT_BR,
    CAT_ILLEGAL
  } inst_cat_e;

  // one instruction word, seen by the class decoder or the register decoder
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [9:0] mid;      // rs2/rs1 or immediate
      logic [2:0] funct3;
      logic [4:0] lo;       // rd or immediate
      logic [6:0] opcode;
    } opc;
    struct packed {
      logic [6:0] top;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] mid;
      logic [4:0] rd;
      logic [6:0] opcode;
    } regs;
  } inst_word_u;

  typedef struct packed {
    logic               valid;
    logic [XLEN_PC-1:0] pc;
    logic [LINE_W-1:0]  data;
  } fetch_line_t;

  typedef struct packed {
    logic                            valid;
    logic [XLEN_PC-1:0]              line_pc;
    logic [WORD_IDX_W-1:0]           start;   // first word not yet dispatched
    inst_word_u [LINE_WORDS-1:0]     words;
  } head_words_t;

  typedef struct packed {
    logic       rd_valid;
    logic [4:0] rd;
    logic       rs1_valid;
    logic [4:0] rs1;
    logic       rs2_valid;
    logic [4:0] rs2;
  } reg_fields_t;

  typedef struct packed {
    logic               valid;
    logic [31:0]        inst;
    logic [XLEN_PC-1:0] pc;
    inst_cat_e          cat;
    reg_fields_t        regs;
  } disp_slot_t;

  typedef struct packed {
    logic                            valid;
    logic [DISP_CNT_W-1:0]           count;
    disp_slot_t [DISP_WIDTH-1:0]     slot;
  } disp_group_t;

endpackage

// ==== design/fetch_line_queue.sv ====
module fetch_line_queue (
  input  logic                                   i_clk,
  input  logic                                   i_reset_n,
  input  logic                                   i_flush,
  input  inst_buffer_pkg::fetch_line_t           i_fetch,
  input  logic [inst_buffer_pkg::DISP_CNT_W-1:0] i_consume_cnt,
  output logic                                   o_fetch_ready,
  output inst_buffer_pkg::head_words_t           o_head
);

  logic [inst_buffer_pkg::XLEN_PC-1:0]    r_pc   [inst_buffer_pkg::INST_BUF_SIZE];
  logic [inst_buffer_pkg::LINE_W-1:0]     r_data [inst_buffer_pkg::INST_BUF_SIZE];
  logic [inst_buffer_pkg::PTR_W-1:0]      r_inptr;
  logic [inst_buffer_pkg::PTR_W-1:0]      r_outptr;
  logic [inst_buffer_pkg::PTR_W:0]        r_count;
  logic [inst_buffer_pkg::WORD_IDX_W-1:0] r_consumed;  // words taken from head line

  logic                                   w_push;
  logic                                   w_pop;
  logic                                   w_not_empty;
  logic [inst_buffer_pkg::XLEN_PC-1:0]    w_head_pc;
  logic [inst_buffer_pkg::WORD_IDX_W:0]   w_start;
  logic [inst_buffer_pkg::WORD_IDX_W:0]   w_sum;

  assign w_not_empty   = (r_count != '0);
  assign o_fetch_ready = (r_count !=
                          (inst_buffer_pkg::PTR_W + 1)'(inst_buffer_pkg::INST_BUF_SIZE));
  assign w_push        = i_fetch.valid & o_fetch_ready;

  assign w_head_pc = r_pc[r_outptr];
  assign w_start   = {1'b0, w_head_pc[inst_buffer_pkg::WORD_IDX_W+1:2]} + {1'b0, r_consumed};
  assign w_sum     = w_start + (inst_buffer_pkg::WORD_IDX_W + 1)'(i_consume_cnt);

  // head line done once the last word goes out
  assign w_pop = w_not_empty & (|i_consume_cnt) &
                 (w_sum >= (inst_buffer_pkg::WORD_IDX_W + 1)'(inst_buffer_pkg::LINE_WORDS));

  // ----------------------------------------------------------------------
  // line storage
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_pc[r_inptr]   <= i_fetch.pc;
      r_data[r_inptr] <= i_fetch.data;
    end
  end

  // ----------------------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_inptr  <= '0;
      r_outptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_inptr  <= '0;
      r_outptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_inptr <= r_inptr + (inst_buffer_pkg::PTR_W)'(1);
      end
      if (w_pop) begin
        r_outptr <= r_outptr + (inst_buffer_pkg::PTR_W)'(1);
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + (inst_buffer_pkg::PTR_W + 1)'(1);
        2'b01:   r_count <= r_count - (inst_buffer_pkg::PTR_W + 1)'(1);
        default: r_count <= r_count;  // none or both
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_consumed <= '0;
    end else if (i_flush || w_pop) begin
      r_consumed <= '0;
    end else begin
      r_consumed <= r_consumed + (inst_buffer_pkg::WORD_IDX_W)'(i_consume_cnt);
    end
  end

  always_comb begin
    o_head.valid   = w_not_empty &
                     (w_start < (inst_buffer_pkg::WORD_IDX_W + 1)'(inst_buffer_pkg::LINE_WORDS));
    o_head.line_pc = w_head_pc;
    o_head.start   = w_start[inst_buffer_pkg::WORD_IDX_W-1:0];
    o_head.words   = r_data[r_outptr];
  end

endmodule

// ==== design/inst_class_decode.sv ====
module inst_class_decode (
  input  inst_buffer_pkg::head_words_t         i_head,
  output inst_buffer_pkg::inst_cat_e           o_cat [inst_buffer_pkg::DISP_WIDTH],
  output logic [inst_buffer_pkg::DISP_WIDTH-1:0] o_in_line
);

  for (genvar k = 0; k < inst_buffer_pkg::DISP_WIDTH; k++) begin : g_slot
    logic [inst_buffer_pkg::WORD_IDX_W:0] w_idx;
    inst_buffer_pkg::inst_word_u          w_word;
    inst_buffer_pkg::inst_cat_e           w_cat;

    assign w_idx  = {1'b0, i_head.start} + (inst_buffer_pkg::WORD_IDX_W + 1)'(k);
    assign w_word = i_head.words[w_idx[inst_buffer_pkg::WORD_IDX_W-1:0]];

    // slot runs past the end of the line
    assign o_in_line[k] = (w_idx <
                           (inst_buffer_pkg::WORD_IDX_W + 1)'(inst_buffer_pkg::LINE_WORDS));

    always_comb begin
      case (w_word.opc.opcode)
        inst_buffer_pkg::OPC_OP,
        inst_buffer_pkg::OPC_OP_IMM,
        inst_buffer_pkg::OPC_LUI,
        inst_buffer_pkg::OPC_AUIPC: begin
          w_cat = inst_buffer_pkg::CAT_ARITH;
        end
        inst_buffer_pkg::OPC_LOAD: begin
          w_cat = inst_buffer_pkg::CAT_LD;
        end
        inst_buffer_pkg::OPC_STORE: begin
          w_cat = inst_buffer_pkg::CAT_ST;
        end
        inst_buffer_pkg::OPC_BRANCH,
        inst_buffer_pkg::OPC_JAL,
        inst_buffer_pkg::OPC_JALR: begin
          w_cat = inst_buffer_pkg::CAT_BR;  // jumps go to the branch unit
        end
        default: begin
          w_cat = inst_buffer_pkg::CAT_ILLEGAL;
        end
      endcase
    end

    assign o_cat[k] = w_cat;
  end

endmodule

// ==== design/reg_field_decode.sv ====
module reg_field_decode (
  input  inst_buffer_pkg::head_words_t i_head,
  output inst_buffer_pkg::reg_fields_t o_regs [inst_buffer_pkg::DISP_WIDTH]
);

  for (genvar k = 0; k < inst_buffer_pkg::DISP_WIDTH; k++) begin : g_slot
    logic [inst_buffer_pkg::WORD_IDX_W:0] w_idx;
    inst_buffer_pkg::inst_word_u          w_word;
    logic [2:0]                           w_use;  // rd, rs1, rs2

    assign w_idx  = {1'b0, i_head.start} + (inst_buffer_pkg::WORD_IDX_W + 1)'(k);
    assign w_word = i_head.words[w_idx[inst_buffer_pkg::WORD_IDX_W-1:0]];

    always_comb begin
      case (w_word.regs.opcode)
        inst_buffer_pkg::OPC_OP:     w_use = 3'b111;
        inst_buffer_pkg::OPC_OP_IMM: w_use = 3'b110;
        inst_buffer_pkg::OPC_LUI:    w_use = 3'b100;
        inst_buffer_pkg::OPC_AUIPC:  w_use = 3'b100;
        inst_buffer_pkg::OPC_LOAD:   w_use = 3'b110;
        inst_buffer_pkg::OPC_STORE:  w_use = 3'b011;
        inst_buffer_pkg::OPC_BRANCH: w_use = 3'b011;
        inst_buffer_pkg::OPC_JAL:    w_use = 3'b100;
        inst_buffer_pkg::OPC_JALR:   w_use = 3'b110;
        default:                     w_use = 3'b000;  // illegal, no operands
      endcase
    end

    always_comb begin
      o_regs[k].rd_valid  = w_use[2];
      o_regs[k].rd        = w_word.regs.rd;
      o_regs[k].rs1_valid = w_use[1];
      o_regs[k].rs1       = w_word.regs.rs1;
      o_regs[k].rs2_valid = w_use[0];
      o_regs[k].rs2       = w_word.regs.rs2;
    end
  end

endmodule

// ==== design/dispatch_group_select.sv ====
module dispatch_group_select (
  input  inst_buffer_pkg::head_words_t           i_head,
  input  inst_buffer_pkg::inst_cat_e             i_cat [inst_buffer_pkg::DISP_WIDTH],
  input  logic [inst_buffer_pkg::DISP_WIDTH-1:0] i_in_line,
  input  inst_buffer_pkg::reg_fields_t           i_regs [inst_buffer_pkg::DISP_WIDTH],
  input  logic                                   i_flush,
  input  logic                                   i_disp_ready,
  output inst_buffer_pkg::disp_group_t           o_disp,
  output logic [inst_buffer_pkg::DISP_CNT_W-1:0] o_consume_cnt
);

  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_live;
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_is_arith;
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_is_mem;
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_is_br;
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_is_illegal;
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_picked;
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_grp;
  logic [inst_buffer_pkg::DISP_CNT_W-1:0] w_cnt;
  logic [inst_buffer_pkg::WORD_IDX_W:0]   w_idx  [inst_buffer_pkg::DISP_WIDTH];
  inst_buffer_pkg::inst_word_u            w_word [inst_buffer_pkg::DISP_WIDTH];

  // first `limit` requesters, lowest slot first
  function automatic logic [inst_buffer_pkg::DISP_WIDTH-1:0] pick_first(
    input logic [inst_buffer_pkg::DISP_WIDTH-1:0] req,
    input int unsigned                            limit
  );
    logic [inst_buffer_pkg::DISP_WIDTH-1:0] grant;
    int unsigned                            taken;
    grant = '0;
    taken = 0;
    for (int i = 0; i < inst_buffer_pkg::DISP_WIDTH; i++) begin
      if (req[i] && (taken < limit)) begin
        grant[i] = 1'b1;
        taken++;
      end
    end
    return grant;
  endfunction

  for (genvar k = 0; k < inst_buffer_pkg::DISP_WIDTH; k++) begin : g_slot
    assign w_idx[k]  = {1'b0, i_head.start} + (inst_buffer_pkg::WORD_IDX_W + 1)'(k);
    assign w_word[k] = i_head.words[w_idx[k][inst_buffer_pkg::WORD_IDX_W-1:0]];

    assign w_live[k]       = i_head.valid & i_in_line[k];
    assign w_is_arith[k]   = w_live[k] & (i_cat[k] == inst_buffer_pkg::CAT_ARITH);
    assign w_is_mem[k]     = w_live[k] & ((i_cat[k] == inst_buffer_pkg::CAT_LD) |
                                          (i_cat[k] == inst_buffer_pkg::CAT_ST));
    assign w_is_br[k]      = w_live[k] & (i_cat[k] == inst_buffer_pkg::CAT_BR);
    assign w_is_illegal[k] = w_live[k] & (i_cat[k] == inst_buffer_pkg::CAT_ILLEGAL);
  end

  assign w_picked = pick_first(w_is_arith,   inst_buffer_pkg::ARITH_DISP_LIMIT)   |
                    pick_first(w_is_mem,     inst_buffer_pkg::MEM_DISP_LIMIT)     |
                    pick_first(w_is_br,      inst_buffer_pkg::BR_DISP_LIMIT)      |
                    pick_first(w_is_illegal, inst_buffer_pkg::ILLEGAL_DISP_LIMIT);

  // ----------------------------------------------------------------------
  // group is the run of picked slots from slot 0
  // ----------------------------------------------------------------------
  always_comb begin
    w_grp[0] = w_picked[0];
    for (int i = 1; i < inst_buffer_pkg::DISP_WIDTH; i++) begin
      w_grp[i] = w_grp[i-1] & w_picked[i];
    end
  end

  always_comb begin
    w_cnt = '0;
    for (int i = 0; i < inst_buffer_pkg::DISP_WIDTH; i++) begin
      w_cnt = w_cnt + (inst_buffer_pkg::DISP_CNT_W)'(w_grp[i]);
    end
  end

  always_comb begin
    o_disp       = '0;
    o_disp.valid = (|w_grp) & ~i_flush;
    o_disp.count = w_cnt;
    for (int i = 0; i < inst_buffer_pkg::DISP_WIDTH; i++) begin
      if (w_grp[i]) begin
        o_disp.slot[i].valid = 1'b1;
        o_disp.slot[i].inst  = w_word[i];
        o_disp.slot[i].pc    = {i_head.line_pc[inst_buffer_pkg::XLEN_PC-1:
                                               inst_buffer_pkg::WORD_IDX_W+2],
                                w_idx[i][inst_buffer_pkg::WORD_IDX_W-1:0], 2'b00};
        o_disp.slot[i].cat   = i_cat[i];
        o_disp.slot[i].regs  = i_regs[i];
      end
    end
  end

  assign o_consume_cnt = (o_disp.valid & i_disp_ready) ? w_cnt : '0;

endmodule

// ==== design/inst_buffer.sv ====
module inst_buffer (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_flush,
  input  inst_buffer_pkg::fetch_line_t i_fetch,
  input  logic                         i_disp_ready,
  output logic                         o_fetch_ready,
  output inst_buffer_pkg::disp_group_t o_disp
);

  inst_buffer_pkg::head_words_t           w_head;
  inst_buffer_pkg::inst_cat_e             w_cat  [inst_buffer_pkg::DISP_WIDTH];
  logic [inst_buffer_pkg::DISP_WIDTH-1:0] w_in_line;
  inst_buffer_pkg::reg_fields_t           w_regs [inst_buffer_pkg::DISP_WIDTH];
  logic [inst_buffer_pkg::DISP_CNT_W-1:0] w_consume_cnt;

  // ----------------------------------------------------------------------
  // line queue
  // ----------------------------------------------------------------------
  fetch_line_queue u_queue (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_fetch       (i_fetch),
    .i_consume_cnt (w_consume_cnt),
    .o_fetch_ready (o_fetch_ready),
    .o_head        (w_head)
  );

  // ----------------------------------------------------------------------
  // decoders, both on the same head words
  // ----------------------------------------------------------------------
  inst_class_decode u_class_dec (
    .i_head    (w_head),
    .o_cat     (w_cat),
    .o_in_line (w_in_line)
  );

  reg_field_decode u_reg_dec (
    .i_head (w_head),
    .o_regs (w_regs)
  );

  dispatch_group_select u_select (
    .i_head        (w_head),
    .i_cat         (w_cat),
    .i_in_line     (w_in_line),
    .i_regs        (w_regs),
    .i_flush       (i_flush),
    .i_disp_ready  (i_disp_ready),
    .o_disp        (o_disp),
    .o_consume_cnt (w_consume_cnt)  // back to queue
  );

endmodule

// ==== verification/inst_buffer_tb.sv ====
module inst_buffer_tb;

  logic                         i_clk;
  logic                         i_reset_n;
  logic                         i_flush;
  logic                         i_disp_ready;
  inst_buffer_pkg::fetch_line_t i_fetch;
  logic                         o_fetch_ready;
  inst_buffer_pkg::disp_group_t o_disp;

  int rem_q[$];  // words left per queued line
  int n_records;
  int fd;

  inst_buffer i_inst_buffer (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_fetch       (i_fetch),
    .i_disp_ready  (i_disp_ready),
    .o_fetch_ready (o_fetch_ready),
    .o_disp        (o_disp)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  // ----------------------------------------------------------------------
  // record handlers
  // ----------------------------------------------------------------------
  task automatic check_idle_state();
    logic exp_ready;
    @(posedge i_clk);
    i_fetch.valid <= 1'b0;
    i_flush       <= 1'b0;
    i_disp_ready  <= 1'b0;
    @(negedge i_clk);
    exp_ready = (rem_q.size() != inst_buffer_pkg::INST_BUF_SIZE);
    assert (o_fetch_ready == exp_ready) else stop_on_error($sformatf(
      "Mismatch o_fetch_ready: got %h, expected %h", o_fetch_ready, exp_ready));
    if (rem_q.size() == 0) begin
      assert (!o_disp.valid) else stop_on_error($sformatf(
        "Mismatch o_disp.valid: got %h, expected %h", o_disp.valid, 1'b0));
    end
  endtask

  task automatic push_line(input logic [31:0] pc, input logic [127:0] data,
                           input bit wait_ready);
    logic exp_ready;
    @(posedge i_clk);
    i_fetch <= '{valid: 1'b1, pc: pc, data: data};
    @(negedge i_clk);
    if (wait_ready) begin
      while (!o_fetch_ready) begin
        @(negedge i_clk);
      end
    end else begin
      exp_ready = (rem_q.size() != inst_buffer_pkg::INST_BUF_SIZE);
      assert (o_fetch_ready == exp_ready) else stop_on_error($sformatf(
        "Mismatch o_fetch_ready: got %h, expected %h", o_fetch_ready, exp_ready));
    end
    if (o_fetch_ready) begin
      rem_q.push_back(inst_buffer_pkg::LINE_WORDS - int'(pc[3:2]));  // taken at next edge
    end
  endtask

  task automatic flush_cycle();
    @(posedge i_clk);
    i_flush      <= 1'b1;
    i_disp_ready <= 1'b1;  // nothing may be consumed
    @(negedge i_clk);
    assert (!o_disp.valid) else stop_on_error($sformatf(
      "Mismatch o_disp.valid: got %h, expected %h", o_disp.valid, 1'b0));
    rem_q.delete();
  endtask

  task automatic expect_group(input int cnt);
    inst_buffer_pkg::disp_group_t exp;
    logic [31:0]                  pc;
    logic [31:0]                  inst;
    int                           cat;
    int                           rdv;
    int                           rs1v;
    int                           rs2v;
    int                           code;
    bit                           done;
    exp       = '0;
    exp.valid = 1'b1;
    exp.count = cnt[1:0];
    for (int i = 0; i < cnt; i++) begin
      code = $fscanf(fd, "%h %h %d %d %d %d", pc, inst, cat, rdv, rs1v, rs2v);
      if (code != 6) begin
        stop_on_error("data file has an incomplete slot in an E record");
      end
      exp.slot[i].valid          = 1'b1;
      exp.slot[i].inst           = inst;
      exp.slot[i].pc             = pc;
      exp.slot[i].cat            = inst_buffer_pkg::inst_cat_e'(cat);
      exp.slot[i].regs.rd_valid  = rdv[0];
      exp.slot[i].regs.rd        = inst[11:7];
      exp.slot[i].regs.rs1_valid = rs1v[0];
      exp.slot[i].regs.rs1       = inst[19:15];
      exp.slot[i].regs.rs2_valid = rs2v[0];
      exp.slot[i].regs.rs2       = inst[24:20];
    end
    if (rem_q.size() == 0) begin
      stop_on_error("an expected group was given while no line is queued");
    end
    done = 1'b0;
    while (!done) begin
      @(posedge i_clk);
      i_disp_ready <= 1'($urandom % 2);
      @(negedge i_clk);
      assert (o_disp == exp) else stop_on_error($sformatf(  // must hold steady under back-pressure
        "Mismatch o_disp: got %h, expected %h", o_disp, exp));
      done = i_disp_ready;
    end
    rem_q[0] = rem_q[0] - cnt;
    if (rem_q[0] <= 0) begin
      rem_q.pop_front();
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int          code;
    int          c;
    int          cnt;
    bit          at_line_start;
    logic [7:0]  rec;
    logic [31:0] pc;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    i_reset_n    = 1'b0;
    i_flush      = 1'b0;
    i_disp_ready = 1'b0;
    i_fetch      = '0;
    n_records    = 0;
    void'($urandom(54));

    fd = $fopen("verification/inst_buffer_testdata.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open the data file");
    end
    at_line_start = 1'b1;  // count records for the watchdog
    c = $fgetc(fd);
    while (c != -1) begin
      if (at_line_start && (c == "L" || c == "P" || c == "E" || c == "F")) begin
        n_records++;
      end
      at_line_start = (c == 10);
      c = $fgetc(fd);
    end
    $fclose(fd);
    fd = $fopen("verification/inst_buffer_testdata.txt", "r");

    repeat (10) @(posedge i_clk);
    i_reset_n <= 1'b1;
    check_idle_state();

    code = $fscanf(fd, " %c", rec);
    while (code == 1) begin
      case (rec)
        "#": begin
          c = $fgetc(fd);
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end
        "L", "P": begin
          code = $fscanf(fd, "%h %h %h %h %h", pc, w0, w1, w2, w3);
          if (code != 5) begin
            stop_on_error("data file has an incomplete line record");
          end
          push_line(pc, {w3, w2, w1, w0}, rec == "L");
          check_idle_state();
        end
        "E": begin
          code = $fscanf(fd, "%d", cnt);
          if (code != 1) begin
            stop_on_error("data file has an E record without a count");
          end
          expect_group(cnt);
          check_idle_state();
        end
        "F": begin
          flush_cycle();
          check_idle_state();
        end
        default: begin
          stop_on_error($sformatf("data file has an unknown record type %c", rec));
        end
      endcase
      code = $fscanf(fd, " %c", rec);
    end
    $fclose(fd);
    $display("** PASS **");
    $finish;
  end

  initial begin
    wait (n_records != 0);
    repeat (200 * n_records + 20) @(posedge i_clk);
    stop_on_error("timeout, the data records did not complete in time");
  end

endmodule

// ==== verification/inst_buffer_testdata.txt ====
# L/P: pc w0 w1 w2 w3 (hex), L waits for ready, P is offered once   F: flush one cycle
# E: count, then per slot: pc inst cat(0 arith 1 ld 2 st 3 br 4 ill) rd_v rs1_v rs2_v
# arith limit, then arith + load
L 00001000 00510093 002081b3 40118233 0080a283
E 2
  00001000 00510093 0 1 1 0
  00001004 002081b3 0 1 1 1
E 2
  00001008 40118233 0 1 1 1
  0000100c 0080a283 1 1 1 0
# memory and branch limits
L 00002000 0080a283 00512623 00208863 020000ef
E 1
  00002000 0080a283 1 1 1 0
E 2
  00002004 00512623 2 0 1 1
  00002008 00208863 3 0 1 1
E 1
  0000200c 020000ef 3 1 0 0
# pc at word 2, next line queued behind it
L 00003008 002081b3 002081b3 12345337 00001397
L 00003010 00008067 ffffffff 00510093 002081b3
E 2
  00003008 12345337 0 1 0 0
  0000300c 00001397 0 1 0 0
E 3
  00003010 00008067 3 1 1 0
  00003014 ffffffff 4 0 0 0
  00003018 00510093 0 1 1 0
E 1
  0000301c 002081b3 0 1 1 1
# flush drops a queued line
L 00004000 00510093 002081b3 40118233 0080a283
F
L 00005004 ffffffff 40118233 0080a283 00512623
E 2
  00005004 40118233 0 1 1 1
  00005008 0080a283 1 1 1 0
E 1
  0000500c 00512623 2 0 1 1
# fill the queue, fifth line refused
P 00006000 00510093 002081b3 00512623 00208863
P 00006010 00510093 002081b3 00512623 00208863
P 00006020 00510093 002081b3 00512623 00208863
P 00006030 00510093 002081b3 00512623 00208863
P 00006040 00510093 002081b3 00512623 00208863
E 3
  00006000 00510093 0 1 1 0
  00006004 002081b3 0 1 1 1
  00006008 00512623 2 0 1 1
E 1
  0000600c 00208863 3 0 1 1
F

// ==== project.f ====
design/inst_buffer_pkg.sv
design/fetch_line_queue.sv
design/inst_class_decode.sv
design/reg_field_decode.sv
design/dispatch_group_select.sv
design/inst_buffer.sv
verification/inst_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the inst_buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  --top-module inst_buffer_tb \
  -f project.f \
  -o inst_buffer_sim

# the log decides the result
./obj_dir/inst_buffer_sim 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failure"
